//--- source/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DC_SETS     16
`define DC_WAYS     2
`define DC_WORDS    4
`define DC_INDEX_W  4
`define DC_OFFSET_W 4
`define DC_TAG_W    24
`define DC_LINE_W   128

// uncached store queue entries
`define DC_WQ_DEPTH 4

`endif

//--- source/dcache_pkg.sv
`default_nettype none
`include "dcache_consts.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        logic [1:0]             word;
        logic [1:0]             byte_sel;
    } addr_fields_t;

    // request address, split or as one word
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } addr_u;

    typedef logic [`DC_WORDS-1:0][31:0] line_t;

    typedef enum logic [2:0] {
        LOOKUP, MISS_DIRTY, WRITEBACK, MISS_CLEAN, REFILL, REFILL_DONE
    } miss_state_e;

    typedef enum logic [2:0] {IDLE, LOAD, QUEUE, RETURN, DONE} unc_state_e;

endpackage

`default_nettype wire

//--- source/mem_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

// one requester's view of the shared line bus
interface mem_if;
    logic                    req;
    logic                    we;
    logic [31:0]             addr;
    logic [`DC_LINE_W-1:0]   wdata;
    logic [`DC_LINE_W/8-1:0] wstrb;
    logic                    ready;
    logic                    ret_valid;   // completes reads and writes
    logic [`DC_LINE_W-1:0]   rdata;

    modport requester (
        output req, we, addr, wdata, wstrb,
        input  ready, ret_valid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata, wstrb,
        output ready, ret_valid, rdata
    );
endinterface

`default_nettype wire

//--- source/tag_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module tag_store (
    input  wire                   clk,
    input  wire                   reset,
    input  wire [`DC_INDEX_W-1:0] rd_index,
    input  wire [`DC_TAG_W-1:0]   cmp_tag,
    input  wire                   fill_we,
    input  wire                   fill_way,
    input  wire [`DC_INDEX_W-1:0] fill_index,
    input  wire [`DC_TAG_W-1:0]   fill_tag,
    input  wire                   dirty_set,
    input  wire                   dirty_way,
    input  wire                   lru_touch,
    input  wire                   lru_way,
    output logic                  hit_way,
    output logic                  hit,
    output logic                  victim_way,
    output logic                  victim_dirty,
    output logic [`DC_TAG_W-1:0]  victim_tag
);

    logic [`DC_TAG_W-1:0]                tags [`DC_WAYS][`DC_SETS];
    logic [`DC_TAG_W-1:0]                tag_q [`DC_WAYS];
    logic [`DC_WAYS-1:0][`DC_SETS-1:0]   valid;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0]   dirty;
    logic [`DC_SETS-1:0]                 lru;   // points at the way to evict
    logic [`DC_INDEX_W-1:0]              index_q;
    logic [`DC_WAYS-1:0]                 hit_vec;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (fill_we) begin
                valid[fill_way][fill_index] <= 1'b1;
                dirty[fill_way][fill_index] <= 1'b0;   // fresh line is clean
            end else if (dirty_set) begin
                dirty[dirty_way][fill_index] <= 1'b1;
            end
            if (lru_touch) lru[fill_index] <= ~lru_way;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) tags[fill_way][fill_index] <= fill_tag;
        index_q <= rd_index;
        for (int w = 0; w < `DC_WAYS; w++) begin
            tag_q[w] <= tags[w][rd_index];
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid[w][index_q] & (tag_q[w] == cmp_tag);
        end
    end

    assign hit          = |hit_vec;
    assign hit_way      = hit_vec[1];
    assign victim_way   = lru[index_q];
    assign victim_dirty = dirty[victim_way][index_q];
    assign victim_tag   = tag_q[victim_way];

endmodule

`default_nettype wire

//--- source/data_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module data_store
    import dcache_pkg::*;
(
    input  wire                           clk,
    input  wire  [`DC_INDEX_W-1:0]        rd_index,
    input  wire                           fill_we,
    input  wire                           fill_way,
    input  wire  [`DC_INDEX_W-1:0]        wr_index,
    input  wire  line_t                   fill_line,
    input  wire                           word_we,
    input  wire  [1:0]                    word_sel,
    input  wire  [31:0]                   word_data,
    input  wire  [3:0]                    word_strb,
    output line_t [`DC_WAYS-1:0]          rd_lines
);

    line_t lines [`DC_WAYS][`DC_SETS];

    always_ff @(posedge clk) begin
        if (fill_we) begin
            lines[fill_way][wr_index] <= fill_line;
        end else if (word_we) begin
            // store hit, only strobed bytes change
            for (int b = 0; b < 4; b++) begin
                if (word_strb[b])
                    lines[fill_way][wr_index][word_sel][8*b +: 8] <= word_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            rd_lines[w] <= lines[w][rd_index];
        end
    end

endmodule

`default_nettype wire

//--- source/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module cache_ctrl
    import dcache_pkg::*;
(
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           req_valid,
    input  wire                           req_write,
    input  wire                           req_uncached,
    input  wire  addr_u                   req_addr,
    input  wire  [31:0]                   req_wdata,
    input  wire  [3:0]                    req_wstrb,
    input  wire                           hit_way,
    input  wire                           hit,
    input  wire                           victim_way,
    input  wire                           victim_dirty,
    input  wire  [`DC_TAG_W-1:0]          victim_tag,
    input  wire  line_t [`DC_WAYS-1:0]    rd_lines,
    output logic                          busy,
    output logic                          resp_valid,
    output logic [31:0]                   resp_rdata,
    output logic [`DC_INDEX_W-1:0]        rd_index,
    output logic [`DC_TAG_W-1:0]          cmp_tag,
    output logic                          fill_we,
    output logic                          fill_way,
    output logic [`DC_INDEX_W-1:0]        fill_index,
    output logic [`DC_TAG_W-1:0]          fill_tag,
    output line_t                         fill_line,
    output logic                          dirty_set,
    output logic                          dirty_way,
    output logic                          lru_touch,
    output logic                          lru_way,
    output logic                          word_we,
    output logic [1:0]                    word_sel,
    output logic [31:0]                   word_data,
    output logic [3:0]                    word_strb,
    mem_if.requester                      mem
);

    miss_state_e state;
    miss_state_e state_nxt;
    logic        accept;
    logic        lookup_hit;
    logic        buf_valid;
    logic        buf_write;
    addr_u       buf_addr;
    logic [31:0] buf_wdata;
    logic [3:0]  buf_wstrb;

    assign accept     = req_valid & ~req_uncached;
    assign lookup_hit = (state == LOOKUP) & buf_valid & hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (accept) begin
            buf_valid <= 1'b1;
        end else if (lookup_hit) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_write <= req_write;
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    // load hits leave busy low so the next request overlaps
    assign busy       = (state != LOOKUP) | (buf_valid & (buf_write | ~hit));
    assign resp_valid = lookup_hit;
    assign resp_rdata = rd_lines[hit_way][buf_addr.f.word];

    // hold the buffered set while a miss is in progress
    assign rd_index   = accept ? req_addr.f.index : buf_addr.f.index;
    assign cmp_tag    = buf_addr.f.tag;

    assign fill_we    = (state == REFILL) & mem.ret_valid;
    assign fill_way   = (state == REFILL) ? victim_way : hit_way;
    assign fill_index = buf_addr.f.index;
    assign fill_tag   = buf_addr.f.tag;
    assign fill_line  = mem.rdata;
    assign dirty_set  = lookup_hit & buf_write;
    assign dirty_way  = hit_way;
    assign lru_touch  = lookup_hit;
    assign lru_way    = hit_way;
    assign word_we    = lookup_hit & buf_write;
    assign word_sel   = buf_addr.f.word;
    assign word_data  = buf_wdata;
    assign word_strb  = buf_wstrb;

    assign mem.req    = (state == MISS_DIRTY) | (state == MISS_CLEAN);
    assign mem.we     = (state == MISS_DIRTY);
    assign mem.addr   = {(state == MISS_DIRTY) ? victim_tag : buf_addr.f.tag,
                         buf_addr.f.index, {`DC_OFFSET_W{1'b0}}};
    assign mem.wdata  = rd_lines[victim_way];   // victim line for writeback
    assign mem.wstrb  = {(`DC_LINE_W/8){state == MISS_DIRTY}};

    always_ff @(posedge clk) begin
        if (reset) state <= LOOKUP;
        else state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LOOKUP: begin
                if (buf_valid & ~hit)
                    state_nxt = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
            end
            MISS_DIRTY:  if (mem.ready) state_nxt = WRITEBACK;
            WRITEBACK:   if (mem.ret_valid) state_nxt = MISS_CLEAN;
            MISS_CLEAN:  if (mem.ready) state_nxt = REFILL;
            REFILL:      if (mem.ret_valid) state_nxt = REFILL_DONE;
            REFILL_DONE: state_nxt = LOOKUP;   // arrays reread, lookup replays
            default:     state_nxt = LOOKUP;
        endcase
    end

    // no line read may go out before the writeback has returned
    assert property (@(posedge clk) disable iff (reset)
        (mem.req && mem.we && mem.ready) |=> !(mem.req && !mem.we) until mem.ret_valid);

endmodule

`default_nettype wire

//--- source/uncache_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module uncache_unit
    import dcache_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         req_valid,
    input  wire         req_write,
    input  wire         req_uncached,
    input  wire  addr_u req_addr,
    input  wire  [31:0] req_wdata,
    input  wire  [3:0]  req_wstrb,
    output logic        busy,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,
    mem_if.requester    mem
);

    localparam int PTR_W = $clog2(`DC_WQ_DEPTH);

    unc_state_e              state;
    unc_state_e              state_nxt;
    addr_u                   u_addr;
    logic [31:0]             u_wdata;
    logic [3:0]              u_wstrb;
    logic [31:0]             load_data;
    addr_u                   q_addr [`DC_WQ_DEPTH];
    logic [31:0]             q_data [`DC_WQ_DEPTH];
    logic [3:0]              q_strb [`DC_WQ_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          count;
    logic                    accept, push, pop, full, empty;
    logic                    drain_wait;   // queued store accepted, awaiting return
    logic                    drain_req, load_req;
    addr_u                   bus_addr;
    logic [3:0]              bus_strb;

    assign accept    = req_valid & req_uncached;
    assign full      = (count == `DC_WQ_DEPTH);
    assign empty     = (count == '0);
    assign push      = (state == QUEUE) & ~full;
    assign drain_req = ~empty & ~drain_wait;
    assign pop       = drain_req & mem.ready;
    // loads go out only once every earlier store has completed
    assign load_req  = (state == LOAD) & empty & ~drain_wait;

    always_ff @(posedge clk) begin
        if (accept) begin
            u_addr  <= req_addr;
            u_wdata <= req_wdata;
            u_wstrb <= req_wstrb;
        end
        if (push) begin
            q_addr[wr_ptr] <= u_addr;
            q_data[wr_ptr] <= u_wdata;
            q_strb[wr_ptr] <= u_wstrb;
        end
        if ((state == RETURN) & mem.ret_valid)
            load_data <= mem.rdata[{u_addr.f.word, 5'b0} +: 32];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            drain_wait <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
            if (pop) drain_wait <= 1'b1;
            else if (mem.ret_valid) drain_wait <= 1'b0;
        end
    end

    assign bus_addr  = drain_req ? q_addr[rd_ptr] : u_addr;
    assign bus_strb  = drain_req ? q_strb[rd_ptr] : 4'hf;
    assign mem.req   = drain_req | load_req;
    assign mem.we    = drain_req;
    assign mem.addr  = {bus_addr.raw[31:2], 2'b00};
    assign mem.wdata = {`DC_WORDS{q_data[rd_ptr]}};   // same word in every lane
    assign mem.wstrb = {{(`DC_LINE_W/8-4){1'b0}}, bus_strb} << {bus_addr.f.word, 2'b00};

    assign busy       = (state == LOAD) | (state == QUEUE) | (state == RETURN);
    assign resp_valid = push | (state == DONE);
    assign resp_rdata = load_data;

    always_ff @(posedge clk) begin
        if (reset) state <= IDLE;
        else state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE: begin
                if (accept) state_nxt = req_write ? QUEUE : LOAD;
                else state_nxt = IDLE;
            end
            LOAD:    if (load_req & mem.ready) state_nxt = RETURN;
            QUEUE:   if (~full) state_nxt = IDLE;   // stalls while the queue is full
            RETURN:  if (mem.ret_valid) state_nxt = DONE;
            default: state_nxt = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module mem_arbiter
    import dcache_pkg::*;
(
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           mem_ready,
    input  wire                           mem_ret_valid,
    input  wire  line_t                   mem_rdata,
    output logic                          mem_req,
    output logic                          mem_we,
    output logic [31:0]                   mem_addr,
    output line_t                         mem_wdata,
    output logic [`DC_LINE_W/8-1:0]       mem_wstrb,
    mem_if.arbiter                        cache_bus,
    mem_if.arbiter                        unc_bus
);

    logic lock;       // held from acceptance until the return
    logic lock_uc;
    logic grant_uc;

    // cache wins ties
    assign grant_uc  = lock ? lock_uc : ~cache_bus.req;
    assign mem_req   = ~lock & (cache_bus.req | unc_bus.req);
    assign mem_we    = grant_uc ? unc_bus.we : cache_bus.we;
    assign mem_addr  = grant_uc ? unc_bus.addr : cache_bus.addr;
    assign mem_wdata = grant_uc ? unc_bus.wdata : cache_bus.wdata;
    assign mem_wstrb = grant_uc ? unc_bus.wstrb : cache_bus.wstrb;

    assign cache_bus.ready     = mem_ready & mem_req & ~grant_uc;
    assign unc_bus.ready       = mem_ready & mem_req & grant_uc;
    assign cache_bus.ret_valid = mem_ret_valid & lock & ~lock_uc;
    assign unc_bus.ret_valid   = mem_ret_valid & lock & lock_uc;
    assign cache_bus.rdata     = mem_rdata;
    assign unc_bus.rdata       = mem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            lock    <= 1'b0;
            lock_uc <= 1'b0;
        end else if (mem_req & mem_ready) begin
            lock    <= 1'b1;
            lock_uc <= grant_uc;
        end else if (mem_ret_valid) begin
            lock    <= 1'b0;
        end
    end

    // granted peer stays off the bus until its return
    assert property (@(posedge clk) disable iff (reset)
        lock |-> !(lock_uc ? unc_bus.req : cache_bus.req));

    // memory must only return what was accepted
    assert property (@(posedge clk) disable iff (reset) mem_ret_valid |-> lock);

endmodule

`default_nettype wire

//--- source/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      req_valid,
    input  wire                      req_write,
    input  wire                      req_uncached,
    input  wire  [31:0]              req_addr,
    input  wire  [31:0]              req_wdata,
    input  wire  [3:0]               req_wstrb,
    output logic                     busy,
    output logic                     resp_valid,
    output logic [31:0]              resp_rdata,
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [31:0]              mem_addr,
    output logic [`DC_LINE_W-1:0]    mem_wdata,
    output logic [`DC_LINE_W/8-1:0]  mem_wstrb,
    input  wire                      mem_ready,
    input  wire                      mem_ret_valid,
    input  wire  [`DC_LINE_W-1:0]    mem_rdata
);

    logic                   accept;
    logic                   c_busy, c_resp_valid;
    logic                   u_busy, u_resp_valid;
    logic [31:0]            c_rdata, u_rdata;
    logic [`DC_INDEX_W-1:0] rd_index, fill_index;
    logic [`DC_TAG_W-1:0]   cmp_tag, fill_tag, victim_tag;
    logic                   hit, hit_way, victim_way, victim_dirty;
    logic                   fill_we, fill_way, dirty_set, dirty_way, lru_touch, lru_way;
    logic                   word_we;
    logic [1:0]             word_sel;
    logic [31:0]            word_data;
    logic [3:0]             word_strb;
    line_t                  fill_line;
    line_t [`DC_WAYS-1:0]   rd_lines;

    mem_if cache_bus ();
    mem_if unc_bus ();

    assign accept     = req_valid & ~busy;   // both peers see only accepted requests
    assign busy       = c_busy | u_busy;
    assign resp_valid = c_resp_valid | u_resp_valid;
    assign resp_rdata = u_resp_valid ? u_rdata : c_rdata;

    cache_ctrl u_cache_ctrl (
        .clk, .reset, .req_valid(accept), .req_write, .req_uncached, .req_addr,
        .req_wdata, .req_wstrb, .hit_way, .hit, .victim_way, .victim_dirty, .victim_tag,
        .rd_lines, .busy(c_busy), .resp_valid(c_resp_valid), .resp_rdata(c_rdata),
        .rd_index, .cmp_tag, .fill_we, .fill_way, .fill_index, .fill_tag, .fill_line,
        .dirty_set, .dirty_way, .lru_touch, .lru_way, .word_we, .word_sel, .word_data,
        .word_strb, .mem(cache_bus)
    );

    tag_store u_tag_store (
        .clk, .reset, .rd_index, .cmp_tag, .fill_we, .fill_way, .fill_index, .fill_tag,
        .dirty_set, .dirty_way, .lru_touch, .lru_way, .hit_way, .hit, .victim_way,
        .victim_dirty, .victim_tag
    );

    data_store u_data_store (
        .clk, .rd_index, .fill_we, .fill_way, .wr_index(fill_index), .fill_line,
        .word_we, .word_sel, .word_data, .word_strb, .rd_lines
    );

    uncache_unit u_uncache_unit (
        .clk, .reset, .req_valid(accept), .req_write, .req_uncached, .req_addr,
        .req_wdata, .req_wstrb, .busy(u_busy), .resp_valid(u_resp_valid),
        .resp_rdata(u_rdata), .mem(unc_bus)
    );

    mem_arbiter u_mem_arbiter (
        .clk, .reset, .mem_ready, .mem_ret_valid, .mem_rdata, .mem_req, .mem_we,
        .mem_addr, .mem_wdata, .mem_wstrb, .cache_bus, .unc_bus
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD = 100.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

`default_nettype wire

//--- tests/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module tb_dcache;

    localparam int NUM_REQ     = 300;
    localparam int NUM_DIRECT  = 6;
    localparam int CYCLE_LIMIT = 400 * (NUM_REQ + NUM_DIRECT) + 20;

    logic                    clk, reset;
    logic                    req_valid, req_write, req_uncached;
    logic [31:0]             req_addr, req_wdata;
    logic [3:0]              req_wstrb;
    logic                    busy, resp_valid;
    logic [31:0]             resp_rdata;
    logic                    mem_req, mem_we;
    logic [31:0]             mem_addr;
    logic [`DC_LINE_W-1:0]   mem_wdata;
    logic [`DC_LINE_W/8-1:0] mem_wstrb;
    logic                    mem_ready, mem_ret_valid;
    logic [`DC_LINE_W-1:0]   mem_rdata;

    logic [31:0] mem_words [logic [31:0]];   // memory model
    logic [31:0] ref_words [logic [31:0]];   // latest stored values
    logic [31:0] uc_order [$];
    logic [23:0] m_tag [16][2];
    logic        m_valid [16][2];
    logic        m_lru [16];
    int          cycle_count = 0;
    int          bus_reads = 0;

    tb_clock u_clock (.clk);

    dcache_top u_dcache_top (
        .clk, .reset, .req_valid, .req_write, .req_uncached, .req_addr, .req_wdata,
        .req_wstrb, .busy, .resp_valid, .resp_rdata, .mem_req, .mem_we, .mem_addr,
        .mem_wdata, .mem_wstrb, .mem_ready, .mem_ret_valid, .mem_rdata
    );

    // contents of words never written
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = data[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] a);
        return mem_words.exists(a) ? mem_words[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        return ref_words.exists(a) ? ref_words[a] : fill_word(a);
    endfunction

    // two-way set with one lru bit naming the way to evict
    function automatic logic cache_access(input logic [3:0] idx, input logic [23:0] tag);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                m_lru[idx] = (w == 0);
                return 1'b1;
            end
        end
        m_tag[idx][m_lru[idx]] = tag;
        m_valid[idx][m_lru[idx]] = 1'b1;
        m_lru[idx] = ~m_lru[idx];
        return 1'b0;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
            fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT)
            fail_run("timeout, the cache stopped responding");
    end

    // memory answers with random ready and return delays
    initial begin
        logic        take;
        logic        outstanding;
        int          rdy_wait;
        int          ret_wait;
        logic [31:0] base;
        logic [`DC_LINE_W-1:0] ret_line;
        take = 1'b0;
        outstanding = 1'b0;
        rdy_wait = 0;
        ret_wait = 0;
        ret_line = '0;
        mem_ready = 1'b0;
        mem_ret_valid = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_ready = 1'b0;
            mem_ret_valid = 1'b0;
            if (take) begin
                outstanding = 1'b1;
                take = 1'b0;
            end else if (outstanding) begin
                if (ret_wait == 0) begin
                    mem_ret_valid = 1'b1;
                    mem_rdata = ret_line;
                    outstanding = 1'b0;
                end else ret_wait--;
            end else if (mem_req && !reset) begin
                if (rdy_wait == 0) begin
                    mem_ready = 1'b1;
                    rdy_wait = $urandom_range(0, 2);
                end else rdy_wait--;
            end
            @(negedge clk);
            if (mem_ready && mem_req) begin   // accepted at the coming edge
                take = 1'b1;
                ret_wait = $urandom_range(0, 3);
                base = {mem_addr[31:4], 4'h0};
                if (mem_we) begin
                    for (int w = 0; w < 4; w++) begin
                        mem_words[base + 4*w] = merge(mem_read(base + 4*w),
                            mem_wdata[32*w +: 32], mem_wstrb[4*w +: 4]);
                    end
                    if (mem_addr[31]) begin
                        check("uncached store order", uc_order.pop_front(), mem_addr);
                    end else begin
                        check("writeback strobes", 32'hffff, mem_wstrb);
                        for (int w = 0; w < 4; w++)
                            check("writeback line", ref_read(base + 4*w), mem_read(base + 4*w));
                    end
                end else begin
                    if (!mem_addr[31]) bus_reads++;
                    for (int w = 0; w < 4; w++) ret_line[32*w +: 32] = mem_read(base + 4*w);
                end
            end
        end
    end

    task automatic do_request(input logic wr, input logic unc, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wstrb);
        logic [31:0] expected;
        logic        predict_hit;
        int          lat;
        int          reads_before;
        predict_hit = 1'b0;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_write = wr;
        req_uncached = unc;
        req_addr = addr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        do @(negedge clk); while (busy);
        expected = ref_read(addr);
        if (wr) ref_words[addr] = merge(expected, wdata, wstrb);
        if (wr && unc) uc_order.push_back(addr);
        if (!unc) predict_hit = cache_access(addr[7:4], addr[31:8]);
        reads_before = bus_reads;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid);
        if (!wr) check(unc ? "uncached load" : "cached load", expected, resp_rdata);
        if (!unc) begin
            check("miss bus read", !predict_hit, bus_reads != reads_before);
            if (predict_hit && !wr) check("load hit latency", 1, lat);
        end
    endtask

    initial begin
        int          kind;
        logic [31:0] addr;
        void'($urandom(32'h8192));
        reset = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_uncached = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int s = 0; s < 16; s++) begin
            m_lru[s] = 1'b0;
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check("reset outputs", 32'h0, {busy, resp_valid, mem_req});

        for (int i = 0; i < NUM_REQ; i++) begin
            kind = $urandom_range(0, 99);
            if (kind < 75) begin
                addr = {24'(24'h10 + $urandom_range(0, 2)), 4'($urandom_range(0, 3)),
                        2'($urandom_range(0, 3)), 2'b00};
                do_request(kind >= 40, 1'b0, addr, $urandom, 4'($urandom_range(1, 15)));
            end else begin
                addr = 32'h8000_0000 | ($urandom_range(0, 7) << 2);
                do_request(kind < 90, 1'b1, addr, $urandom, 4'($urandom_range(1, 15)));
            end
        end

        // queue fills with stores to one word and the load sees the last
        for (int i = 0; i < NUM_DIRECT - 1; i++)
            do_request(1'b1, 1'b1, 32'h8000_0010, $urandom, 4'hf);
        do_request(1'b0, 1'b1, 32'h8000_0010, 32'h0, 4'h0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/dcache_pkg.sv
source/mem_if.sv
source/tag_store.sv
source/data_store.sv
source/cache_ctrl.sv
source/uncache_unit.sv
source/mem_arbiter.sv
source/dcache_top.sv
tests/tb_clock.sv
tests/tb_dcache.sv
